//--- bpred.f
hw/bpred_isa_pkg.sv
hw/bpred_cfg_pkg.sv
hw/branch_classifier.sv
hw/pattern_history_table.sv
hw/predictor_stats_wb.sv
hw/branch_predictor_top.sv
tests/tb_bpred.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the bpred testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f bpred.f \
	--top-module tb_bpred \
	-o tb_bpred

./obj_dir/tb_bpred

//--- tests/bpred_stim.txt
# P fetch_pc expected_taken | X advance instr xpc taken | W we adr wdata expected_rdata
# all fields hex, index is {pc[7:2], last two outcomes}, counts noted as R/M
P 0000000000001000 1
P 0000000000002040 1
W 0 0 00000000 00000000
W 0 1 00000000 00000000
X 1 80000000 0000000000001000 0
P 0000000000001000 0
X 1 80000000 0000000000001000 0
P 0000000000001000 0
X 1 80000000 0000000000001000 0
P 0000000000001000 0
# walk back up, two not-taken branches at 0x2040 restore history 00
X 1 82000000 0000000000001000 1
X 1 40000000 0000000000002040 0
X 1 60000000 0000000000002040 0
X 1 64000000 0000000000002040 0
P 0000000000001000 0
X 1 80000000 0000000000001000 1
X 1 60000000 0000000000002040 0
X 1 60000000 0000000000002040 0
P 0000000000001000 1
X 1 80000000 0000000000001000 1
# same pc under histories 01, 10, 00
P 0000000000002040 0
X 1 60000000 0000000000002040 0
P 0000000000002040 0
X 1 60000000 0000000000002040 0
P 0000000000002040 1
P 0000000000001000 1
X 1 92000000 0000000000001000 1
X 1 64000000 0000000000002040 0
X 1 64000000 0000000000002040 0
X 1 80000000 0000000000001000 0
P 0000000000001000 1
# stalled branch and non-branch opcodes leave table and counts alone
X 0 80000000 0000000000001000 0
X 1 08000000 0000000000001000 0
X 1 00000000 0000000000001000 0
P ffffffff00001000 1
# R=16 M=6, then clear
W 0 0 00000000 00000010
W 0 1 00000000 00000006
W 0 2 00000000 00000000
W 1 0 00000000 00000000
W 0 0 00000000 00000000
W 0 1 00000000 00000000

//--- tests/tb_bpred.sv
`timescale 1ns/1ps

module tb_bpred import bpred_isa_pkg::*, bpred_cfg_pkg::*; ();

	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 4;
	localparam int    NS_PER_LINE  = 200;
	localparam int    ACK_WAIT     = 4;
	localparam int    SAMPLE_DELAY = 2;
	localparam string STIM_FILE    = "tests/bpred_stim.txt";

	logic     clk;
	logic     rst;
	pc_t      fetch_pc;
	logic     predict_taken;
	resolve_t resolve;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;

	// number of compares done, and the watchdog budget once the file is counted
	int          n_checks;
	int unsigned limit_ns;

	branch_predictor_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.predict_taken (predict_taken),
		.resolve       (resolve),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==========================================================================
	// failure and compare helpers
	// ==========================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pred(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s predicted %b, expected %b", $time, what, got, exp);
			abort_run("prediction differs from the counter rule");
		end
	endtask

	task automatic check_word(input wb_word_t got, input wb_word_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
			abort_run("statistics word differs from the precomputed count");
		end
	endtask

	// ==========================================================================
	// command drivers, each starts and ends on a falling edge
	// ==========================================================================

	// fetch probe, answer is combinational so sample well before the rising edge
	task automatic fetch_probe(input pc_t pc, input logic exp);
		fetch_pc = pc;
		#(SAMPLE_DELAY);
		check_pred(predict_taken, exp, $sformatf("fetch pc %h", pc));
		@(negedge clk);
	endtask

	// one execute stage slot
	task automatic execute_slot(input logic adv, input instr_t ir, input pc_t xpc, input logic tk);
		resolve.advance = adv;
		resolve.ir      = ir;
		resolve.xpc     = xpc;
		resolve.taken   = tk;
		@(negedge clk);
		resolve.advance = 1'b0;
	endtask

	// classic cycle, held through the rising edge that sees ack
	task automatic wb_access(input logic we, input logic [1:0] adr, input wb_word_t wdat,
			input wb_word_t exp);
		int waited;
		waited     = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge clk);
		while (!wb_rsp.ack && waited < ACK_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_rsp.ack) begin
			abort_run("wishbone slave gave no ack within 4 cycles");
		end else begin
			if (!we) begin
				check_word(wb_rsp.dat, exp, $sformatf("wishbone address %0d", adr));
			end
			@(negedge clk);
			wb_req.cyc = 1'b0;
			wb_req.stb = 1'b0;
			wb_req.we  = 1'b0;
			// second high cycle would mean a double ack
			if (wb_rsp.ack) begin
				abort_run("wishbone ack stayed high for a second cycle");
			end
		end
	endtask

	// ==========================================================================
	// watchdog, armed once the number of commands is known
	// ==========================================================================

	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		abort_run($sformatf("watchdog timeout after %0d ns, stimulus did not finish", limit_ns));
	end

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		int          fd;
		int          rc;
		int          n_cmds;
		string       line;
		logic [7:0]  cmd;
		logic [63:0] f1;
		logic [63:0] f2;
		logic [63:0] f3;
		logic [63:0] f4;

		clk      = 1'b0;
		rst      = 1'b1;
		fetch_pc = '0;
		resolve  = '0;
		wb_req   = '0;
		n_checks = 0;
		limit_ns = 0;
		n_cmds   = 0;
		void'($urandom(32'h57ca55fd));

		// first pass only counts command lines for the watchdog
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			abort_run({"cannot open stimulus file ", STIM_FILE});
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				if (rc > 0 && (line.getc(0) == "P" || line.getc(0) == "X" ||
						line.getc(0) == "W")) begin
					n_cmds++;
				end
			end
			$fclose(fd);
			limit_ns = n_cmds * NS_PER_LINE + RESET_CYCLES * CLK_PERIOD;

			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;

			fd = $fopen(STIM_FILE, "r");
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				// comment and blank lines carry no command
				if (rc > 1 && line.getc(0) != "#") begin
					f1 = '0;
					f2 = '0;
					f3 = '0;
					f4 = '0;
					rc = $sscanf(line, "%c %h %h %h %h", cmd, f1, f2, f3, f4);
					case (cmd)
						"P": fetch_probe(f1, f2[0]);
						"X": execute_slot(f1[0], instr_t'(f2[31:0]), f3, f4[0]);
						"W": wb_access(f1[0], f2[1:0], wb_word_t'(f3[31:0]),
								wb_word_t'(f4[31:0]));
						default: abort_run({"unknown command in stimulus line: ", line});
					endcase
					// quiet gap, no advance and no bus cycle
					repeat ($urandom_range(3, 0)) @(negedge clk);
				end
			end
			$fclose(fd);

			if (n_checks > 0) begin
				$display("Regression passed");
				$finish;
			end else begin
				abort_run("stimulus file held no checks");
			end
		end
	end

endmodule

//--- hw/branch_predictor_top.sv
`timescale 1ns/1ps

module branch_predictor_top import bpred_cfg_pkg::*; #(
	parameter int PC_IDX_BITS = 6,
	parameter int GHR_BITS    = 2
) (
	input  logic     clk,
	input  logic     rst,
	// fetch side
	input  pc_t      fetch_pc,
	output logic     predict_taken,
	// execute side
	input  resolve_t resolve,
	// statistics bus
	input  wb_req_t  wb_req,
	output wb_rsp_t  wb_rsp
);

	// decode result for the instruction in execute
	logic          is_branch;
	// one resolved branch per update cycle
	branch_event_t branch_event;

	// ==========================================================================
	// execute decode
	// ==========================================================================

	branch_classifier classifier_i (
		.ir        (resolve.ir),
		.is_branch (is_branch)
	);

	// ==========================================================================
	// counter table and history
	// ==========================================================================

	pattern_history_table #(
		.PC_IDX_BITS (PC_IDX_BITS),
		.GHR_BITS    (GHR_BITS)
	) pht_i (
		.clk           (clk),
		.rst           (rst),
		.fetch_pc      (fetch_pc),
		.resolve       (resolve),
		.is_branch     (is_branch),
		.predict_taken (predict_taken),
		.branch_event  (branch_event)
	);

	// ==========================================================================
	// statistics
	// ==========================================================================

	predictor_stats_wb stats_i (
		.clk          (clk),
		.rst          (rst),
		.branch_event (branch_event),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp)
	);

endmodule

//--- hw/predictor_stats_wb.sv
`timescale 1ns/1ps

module predictor_stats_wb import bpred_cfg_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  branch_event_t branch_event,
	input  wb_req_t       wb_req,
	output wb_rsp_t       wb_rsp
);

	// statistics counts, both wrap
	wb_word_t resolved_cnt;
	wb_word_t mispred_cnt;

	// bus side
	logic     ack_q;
	wb_word_t rd_q;
	wb_word_t rd_mux;
	logic     req_new;
	logic     clear;

	// ==========================================================================
	// wishbone slave
	// ==========================================================================

	// a fresh request, held by the master until our ack
	assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

	// write to word 0 clears on the edge that completes the handshake
	assign clear = ack_q && wb_req.cyc && wb_req.stb && wb_req.we && (wb_req.adr == 2'd0);

	// read map, upper words read as zero
	always_comb begin
		case (wb_req.adr)
			2'd0:    rd_mux = resolved_cnt;
			2'd1:    rd_mux = mispred_cnt;
			default: rd_mux = '0;
		endcase
	end

	// ack one clock after the request, then low for at least a cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_new;
		end
	end

	// read data captured with the request
	always_ff @(posedge clk) begin
		if (req_new) begin
			rd_q <= rd_mux;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_q;

	// ==========================================================================
	// counters
	// ==========================================================================

	// clear beats an event on the same edge
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			resolved_cnt <= '0;
			mispred_cnt  <= '0;
		end else if (branch_event.valid) begin
			resolved_cnt <= resolved_cnt + 1'b1;
			if (branch_event.mispredict) begin
				mispred_cnt <= mispred_cnt + 1'b1;
			end
		end
	end

	// single cycle ack per access
	assert property (@(posedge clk) disable iff (rst) ack_q |=> !ack_q)
		else $error("wishbone ack held for two cycles");

endmodule

//--- hw/pattern_history_table.sv
`timescale 1ns/1ps

module pattern_history_table import bpred_cfg_pkg::*; #(
	parameter int PC_IDX_BITS = 6,
	parameter int GHR_BITS    = 2
) (
	input  logic          clk,
	input  logic          rst,
	input  pc_t           fetch_pc,
	input  resolve_t      resolve,
	input  logic          is_branch,
	output logic          predict_taken,
	output branch_event_t branch_event
);

	// table geometry
	localparam int IDX_BITS = PC_IDX_BITS + GHR_BITS;
	localparam int DEPTH    = 1 << IDX_BITS;

	typedef logic [IDX_BITS-1:0] idx_t;

	// counter array and global history
	ctr_t                table_q [DEPTH];
	logic [GHR_BITS-1:0] ghr;

	// fetch and execute side
	idx_t fetch_idx;
	idx_t exec_idx;
	ctr_t fetch_ctr;
	ctr_t exec_ctr;
	ctr_t exec_ctr_next;
	logic update;

	// counter direction, upper bit clear means taken
	function automatic logic ctr_taken(input ctr_t c);
		return !c[1];
	endfunction

	// saturating step in the core encoding
	// taken walks 2 -> 3 -> 0 -> 1, not taken walks back and holds at 2
	function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
		ctr_t n;
		n = c;
		if (taken) begin
			case (c)
				CTR_STRONG_NT: n = CTR_WEAK_NT;
				CTR_WEAK_NT:   n = CTR_WEAK_T;
				CTR_WEAK_T:    n = CTR_STRONG_T;
				default:       n = CTR_STRONG_T;
			endcase
		end else begin
			case (c)
				CTR_STRONG_T:  n = CTR_WEAK_T;
				CTR_WEAK_T:    n = CTR_WEAK_NT;
				CTR_WEAK_NT:   n = CTR_STRONG_NT;
				default:       n = CTR_STRONG_NT;
			endcase
		end
		return n;
	endfunction

	// ==========================================================================
	// index forming and reads
	// ==========================================================================

	// word address bits of the pc on top, recent outcomes below
	assign fetch_idx = {fetch_pc[PC_IDX_BITS+1:2], ghr};
	assign exec_idx  = {resolve.xpc[PC_IDX_BITS+1:2], ghr};

	// both reads see the table before any write on this edge
	assign fetch_ctr = table_q[fetch_idx];
	assign exec_ctr  = table_q[exec_idx];

	// same cycle answer for fetch
	assign predict_taken = ctr_taken(fetch_ctr);

	// ==========================================================================
	// update
	// ==========================================================================

	assign update        = resolve.advance && is_branch;
	assign exec_ctr_next = ctr_step(exec_ctr, resolve.taken);

	// mispredict judged by the counter read at execute
	assign branch_event.valid      = update;
	assign branch_event.taken      = resolve.taken;
	assign branch_event.mispredict = update && (ctr_taken(exec_ctr) != resolve.taken);

	// write uses the history before the shift
	always_ff @(posedge clk) begin
		if (rst) begin
			// every entry starts weakly taken
			for (int i = 0; i < DEPTH; i++) begin
				table_q[i] <= CTR_WEAK_T;
			end
			ghr <= '0;
		end else if (update) begin
			table_q[exec_idx] <= exec_ctr_next;
			// newest outcome enters at bit 0, oldest falls off the top
			ghr <= GHR_BITS'({ghr, resolve.taken});
		end
	end

	// both reads must land inside the array
	assert property (@(posedge clk) disable iff (rst) int'(fetch_idx) < DEPTH)
		else $error("fetch index out of table range");
	assert property (@(posedge clk) disable iff (rst) int'(exec_idx) < DEPTH)
		else $error("execute index out of table range");

	// an event reaching the statistics block needs a stage advance behind it
	assert property (@(posedge clk) disable iff (rst) branch_event.valid |-> resolve.advance)
		else $error("branch event without execute advance");

endmodule

//--- hw/branch_classifier.sv
`timescale 1ns/1ps

module branch_classifier import bpred_isa_pkg::*; (
	input  instr_t ir,
	output logic   is_branch
);

	// major opcode of the execute stage instruction
	opcode_t opcode;

	assign opcode = opcode_t'(ir[OPC_MSB:OPC_LSB]);

	// ==========================================================================
	// opcode decode
	// ==========================================================================

	// anything that resolves a direction trains the table
	// traps count as branches since they are conditional on a compare
	always_comb begin
		case (opcode)
			BEQI, BNEI,
			BLTI, BLEI,
			BGTI, BGEI,
			BLTUI, BLEUI,
			BGTUI, BGEUI:
				is_branch = 1'b1;
			BTRR, BTRI:
				is_branch = 1'b1;
			TRAPCC, TRAPCCI:
				is_branch = 1'b1;
			default:
				is_branch = 1'b0;
		endcase
	end

	// a known instruction word must give a clean decode
	// the table and the counts both act on this bit
	always_comb begin
		if (!$isunknown(ir)) begin
			assert (!$isunknown(is_branch))
				else $error("branch decode unknown for known instruction %h", ir);
		end
	end

endmodule

//--- hw/bpred_cfg_pkg.sv
package bpred_cfg_pkg;

	// ==========================================================================
	// predictor state and vectors
	// ==========================================================================

	// full program counter of the core
	typedef logic [63:0] pc_t;

	// one wishbone data word, also the width of each statistics count
	typedef logic [31:0] wb_word_t;

	// two-bit counter, core encoding
	// upper bit set means the counter predicts not taken
	typedef enum logic [1:0] {
		CTR_WEAK_T    = 2'd0,
		CTR_STRONG_T  = 2'd1,
		CTR_STRONG_NT = 2'd2,
		CTR_WEAK_NT   = 2'd3
	} ctr_t;

	// ==========================================================================
	// structs between core, predictor and bus
	// ==========================================================================

	// execute stage resolution, qualified by advance
	typedef struct packed {
		logic                 advance;
		bpred_isa_pkg::instr_t ir;
		pc_t                  xpc;
		logic                 taken;
	} resolve_t;

	// one resolved branch, valid only in its update cycle
	typedef struct packed {
		logic valid;
		logic taken;
		logic mispredict;
	} branch_event_t;

	// wishbone classic request from the master
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr;
		wb_word_t   dat;
	} wb_req_t;

	// wishbone reply, ack is the only termination
	typedef struct packed {
		logic     ack;
		wb_word_t dat;
	} wb_rsp_t;

endpackage

//--- hw/bpred_isa_pkg.sv
package bpred_isa_pkg;

	// ==========================================================================
	// instruction word and major opcode
	// ==========================================================================

	// one fetched or executed instruction
	typedef logic [31:0] instr_t;

	// major opcode sits in the top seven bits of the word
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 25;

	// major opcodes seen by the predictor
	// only branches and traps matter here, the rest are filler for stimulus
	typedef enum logic [6:0] {
		// non-branch opcodes
		NOP     = 7'h00,
		ADDI    = 7'h04,
		LW      = 7'h20,
		SW      = 7'h28,
		// register branches and conditional traps
		BTRR    = 7'h30,
		BTRI    = 7'h31,
		TRAPCC  = 7'h32,
		TRAPCCI = 7'h33,
		// compare-immediate branches
		BEQI    = 7'h40,
		BNEI    = 7'h41,
		BLTI    = 7'h42,
		BLEI    = 7'h43,
		BGTI    = 7'h44,
		BGEI    = 7'h45,
		BLTUI   = 7'h46,
		BLEUI   = 7'h47,
		BGTUI   = 7'h48,
		BGEUI   = 7'h49
	} opcode_t;

endpackage
